//--- hdl/tinyrv_pkg.sv
// Shared widths, opcode and ALU enums, and instruction field constants for the tinyrv core
`default_nettype none

package tinyrv_pkg;

  // Data path and register index widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // Operations carried from decode into the ALU
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // funct3 values for OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 values for BRANCH
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // funct7 values for OP
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // ADDI x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

//--- hdl/tinyrv_if_stage.sv
// Fetch stage: pc, req/gnt/rvalid handshake with one outstanding fetch, and the IF/ID register
`timescale 1ns/1ps
`default_nettype none

module tinyrv_if_stage (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         fetch_enable_i,
  input  logic [tinyrv_pkg::XLEN-1:0]  boot_addr_i,

  // Redirect from EX
  input  logic                         branch_taken_i,
  input  logic [tinyrv_pkg::XLEN-1:0]  branch_target_i,

  // Instruction memory port
  output logic                         instr_req_o,
  output logic [tinyrv_pkg::XLEN-1:0]  instr_addr_o,
  input  logic                         instr_gnt_i,
  input  logic                         instr_rvalid_i,
  input  logic [tinyrv_pkg::XLEN-1:0]  instr_rdata_i,

  // IF/ID register
  output logic                         ifid_valid_o,
  output logic [tinyrv_pkg::XLEN-1:0]  ifid_pc_o,
  output logic [tinyrv_pkg::XLEN-1:0]  ifid_instr_o
);

  import tinyrv_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] addr_q;
  logic            hold_q;
  logic            outstanding_q;
  logic            kill_q;
  logic            gnt_fire;

  // A request waiting for gnt keeps its address even after a redirect
  assign instr_req_o  = hold_q | (fetch_enable_i & ~outstanding_q);
  assign instr_addr_o = hold_q ? addr_q : pc_q;
  assign gnt_fire     = instr_req_o & instr_gnt_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q          <= boot_addr_i;
      hold_q        <= 1'b0;
      outstanding_q <= 1'b0;
      kill_q        <= 1'b0;
    end else begin
      if (branch_taken_i) begin
        pc_q <= branch_target_i;
      end else if (gnt_fire && !kill_q) begin
        pc_q <= pc_q + 32'd4;
      end

      hold_q <= instr_req_o & ~instr_gnt_i;

      if (gnt_fire) begin
        outstanding_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end

      // Fetch in flight during a redirect is on the wrong path
      if (instr_rvalid_i) begin
        kill_q <= 1'b0;
      end else if (branch_taken_i && (instr_req_o || outstanding_q)) begin
        kill_q <= 1'b1;
      end
    end
  end

  // Last requested address, which is also the pc of the outstanding fetch
  always_ff @(posedge clk_i) begin
    if (instr_req_o) begin
      addr_q <= instr_addr_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || branch_taken_i) begin
      ifid_valid_o <= 1'b0;
      ifid_instr_o <= NOP_INSTR;
    end else if (instr_rvalid_i && !kill_q) begin
      ifid_valid_o <= 1'b1;
      ifid_instr_o <= instr_rdata_i;
    end else begin
      ifid_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_rvalid_i) begin
      ifid_pc_o <= addr_q;
    end
  end

endmodule

`default_nettype wire

//--- hdl/tinyrv_id_stage.sv
// Decode stage: instruction decoder, immediates, operand select and the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module tinyrv_id_stage (
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  input  logic                              ifid_valid_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       ifid_pc_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       ifid_instr_i,

  // Register reads, already forwarded by the core
  output logic [tinyrv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [tinyrv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [tinyrv_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       rs2_data_i,

  input  logic                              flush_i,

  // ID/EX register
  output logic                              idex_valid_o,
  output logic [tinyrv_pkg::XLEN-1:0]       idex_pc_o,
  output tinyrv_pkg::alu_op_e               idex_alu_op_o,
  output logic [tinyrv_pkg::XLEN-1:0]       idex_operand_a_o,
  output logic [tinyrv_pkg::XLEN-1:0]       idex_operand_b_o,
  output logic [tinyrv_pkg::REG_ADDR_W-1:0] idex_rd_o,
  output logic                              idex_we_o,
  output logic                              idex_is_branch_o,
  output logic                              idex_branch_ne_o,
  output logic                              idex_is_jal_o,
  output logic [tinyrv_pkg::XLEN-1:0]       idex_branch_target_o,
  output logic                              idex_illegal_o
);

  import tinyrv_pkg::*;

  opcode_e         opc;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  alu_op_e         alu_op;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] branch_target;
  logic            we;
  logic            is_branch;
  logic            branch_ne;
  logic            is_jal;
  logic            illegal;

  assign opc        = opcode_e'(ifid_instr_i[6:0]);
  assign funct3     = ifid_instr_i[14:12];
  assign funct7     = ifid_instr_i[31:25];
  assign rs1_addr_o = ifid_instr_i[19:15];
  assign rs2_addr_o = ifid_instr_i[24:20];

  assign imm_i = {{20{ifid_instr_i[31]}}, ifid_instr_i[31:20]};
  assign imm_u = {ifid_instr_i[31:12], 12'b0};
  assign imm_b = {{19{ifid_instr_i[31]}}, ifid_instr_i[31], ifid_instr_i[7],
                  ifid_instr_i[30:25], ifid_instr_i[11:8], 1'b0};
  assign imm_j = {{11{ifid_instr_i[31]}}, ifid_instr_i[31], ifid_instr_i[19:12],
                  ifid_instr_i[20], ifid_instr_i[30:21], 1'b0};

  always_comb begin
    alu_op        = ALU_ADD;
    operand_a     = rs1_data_i;
    operand_b     = rs2_data_i;
    branch_target = ifid_pc_i + imm_b;
    we            = 1'b0;
    is_branch     = 1'b0;
    branch_ne     = 1'b0;
    is_jal        = 1'b0;
    illegal       = 1'b0;

    case (opc)
      OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        operand_b = imm_u;
        we        = 1'b1;
      end
      OPC_OP_IMM: begin
        operand_b = imm_i;
        we        = 1'b1;
        case (funct3)
          F3_ADD_SUB: alu_op = ALU_ADD;
          F3_SLT:     alu_op = ALU_SLT;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    illegal = 1'b1;
        endcase
      end
      OPC_OP: begin
        we = 1'b1;
        if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
          alu_op = ALU_SUB;
        end else if (funct7 == F7_BASE) begin
          case (funct3)
            F3_ADD_SUB: alu_op = ALU_ADD;
            F3_SLT:     alu_op = ALU_SLT;
            F3_XOR:     alu_op = ALU_XOR;
            F3_OR:      alu_op = ALU_OR;
            F3_AND:     alu_op = ALU_AND;
            default:    illegal = 1'b1;
          endcase
        end else begin
          illegal = 1'b1;
        end
      end
      OPC_BRANCH: begin
        is_branch = 1'b1;
        if (funct3 == F3_BNE) begin
          branch_ne = 1'b1;
        end else if (funct3 != F3_BEQ) begin
          illegal = 1'b1;
        end
      end
      OPC_JAL: begin
        // Link value pc + 4 comes out of the adder
        is_jal        = 1'b1;
        operand_a     = ifid_pc_i;
        operand_b     = 32'd4;
        branch_target = ifid_pc_i + imm_j;
        we            = 1'b1;
      end
      default: illegal = 1'b1;
    endcase

    // Illegal encodings retire as no-ops
    if (illegal || ifid_instr_i == NOP_INSTR) begin
      we        = 1'b0;
      is_branch = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      idex_valid_o     <= 1'b0;
      idex_we_o        <= 1'b0;
      idex_is_branch_o <= 1'b0;
      idex_is_jal_o    <= 1'b0;
      idex_illegal_o   <= 1'b0;
    end else begin
      idex_valid_o     <= ifid_valid_i;
      idex_we_o        <= we;
      idex_is_branch_o <= is_branch;
      idex_is_jal_o    <= is_jal;
      idex_illegal_o   <= illegal;
    end
  end

  always_ff @(posedge clk_i) begin
    idex_pc_o            <= ifid_pc_i;
    idex_alu_op_o        <= alu_op;
    idex_operand_a_o     <= operand_a;
    idex_operand_b_o     <= operand_b;
    idex_rd_o            <= ifid_instr_i[11:7];
    idex_branch_ne_o     <= branch_ne;
    idex_branch_target_o <= branch_target;
  end

endmodule

`default_nettype wire

//--- hdl/tinyrv_ex_stage.sv
// Execute stage: ALU, branch and jump resolution, writeback and registered retirement
`timescale 1ns/1ps
`default_nettype none

module tinyrv_ex_stage (
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  // ID/EX register
  input  logic                              idex_valid_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       idex_pc_i,
  input  tinyrv_pkg::alu_op_e               idex_alu_op_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       idex_operand_a_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       idex_operand_b_i,
  input  logic [tinyrv_pkg::REG_ADDR_W-1:0] idex_rd_i,
  input  logic                              idex_we_i,
  input  logic                              idex_is_branch_i,
  input  logic                              idex_branch_ne_i,
  input  logic                              idex_is_jal_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       idex_branch_target_i,
  input  logic                              idex_illegal_i,

  // Register file write and forwarding source
  output logic                              wb_we_o,
  output logic [tinyrv_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [tinyrv_pkg::XLEN-1:0]       wb_wdata_o,

  // Redirect
  output logic                              branch_taken_o,
  output logic [tinyrv_pkg::XLEN-1:0]       branch_target_o,

  // Retirement trace
  output logic                              retire_valid_o,
  output logic [tinyrv_pkg::XLEN-1:0]       retire_pc_o,
  output logic                              retire_we_o,
  output logic [tinyrv_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [tinyrv_pkg::XLEN-1:0]       retire_wdata_o,
  output logic                              retire_illegal_o
);

  import tinyrv_pkg::*;

  logic [XLEN-1:0] alu_result;
  logic            operands_equal;

  always_comb begin
    case (idex_alu_op_i)
      ALU_ADD:    alu_result = idex_operand_a_i + idex_operand_b_i;
      ALU_SUB:    alu_result = idex_operand_a_i - idex_operand_b_i;
      ALU_AND:    alu_result = idex_operand_a_i & idex_operand_b_i;
      ALU_OR:     alu_result = idex_operand_a_i | idex_operand_b_i;
      ALU_XOR:    alu_result = idex_operand_a_i ^ idex_operand_b_i;
      ALU_SLT:    alu_result = {31'b0, $signed(idex_operand_a_i) < $signed(idex_operand_b_i)};
      ALU_PASS_B: alu_result = idex_operand_b_i;
      default:    alu_result = '0;
    endcase
  end

  // BNE inverts the equality result
  assign operands_equal  = (idex_operand_a_i == idex_operand_b_i);
  assign branch_taken_o  = idex_valid_i &
                           ((idex_is_branch_i & (operands_equal ^ idex_branch_ne_i)) |
                            idex_is_jal_i);
  assign branch_target_o = idex_branch_target_i;

  assign wb_we_o    = idex_valid_i & idex_we_i & (idex_rd_i != '0);
  assign wb_rd_o    = idex_rd_i;
  assign wb_wdata_o = alu_result;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= idex_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    retire_pc_o      <= idex_pc_i;
    retire_we_o      <= wb_we_o;
    retire_rd_o      <= idex_rd_i;
    retire_wdata_o   <= wb_we_o ? alu_result : '0;
    retire_illegal_o <= idex_illegal_i;
  end

endmodule

`default_nettype wire

//--- hdl/tinyrv_core.sv
// Three-stage pipeline top with the register file and EX-to-ID forwarding
`timescale 1ns/1ps
`default_nettype none

module tinyrv_core (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              fetch_enable_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       boot_addr_i,

  // Instruction memory port
  output logic                              instr_req_o,
  output logic [tinyrv_pkg::XLEN-1:0]       instr_addr_o,
  input  logic                              instr_gnt_i,
  input  logic                              instr_rvalid_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       instr_rdata_i,

  // Retirement trace
  output logic                              retire_valid_o,
  output logic [tinyrv_pkg::XLEN-1:0]       retire_pc_o,
  output logic                              retire_we_o,
  output logic [tinyrv_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [tinyrv_pkg::XLEN-1:0]       retire_wdata_o,
  output logic                              retire_illegal_o
);

  import tinyrv_pkg::*;

  logic                  ifid_valid;
  logic [XLEN-1:0]       ifid_pc;
  logic [XLEN-1:0]       ifid_instr;

  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;

  logic                  idex_valid;
  logic [XLEN-1:0]       idex_pc;
  alu_op_e               idex_alu_op;
  logic [XLEN-1:0]       idex_operand_a;
  logic [XLEN-1:0]       idex_operand_b;
  logic [REG_ADDR_W-1:0] idex_rd;
  logic                  idex_we;
  logic                  idex_is_branch;
  logic                  idex_branch_ne;
  logic                  idex_is_jal;
  logic [XLEN-1:0]       idex_branch_target;
  logic                  idex_illegal;

  logic                  wb_we;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_wdata;
  logic                  branch_taken;
  logic [XLEN-1:0]       branch_target;

  // x0 has no storage
  logic [XLEN-1:0]       rf_q [1:31];

  always_ff @(posedge clk_i) begin
    if (wb_we) begin
      rf_q[wb_rd] <= wb_wdata;
    end
  end

  // EX result overrides the stored value for a matching source
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else if (wb_we && wb_rd == rs1_addr) begin
      rs1_data = wb_wdata;
    end else begin
      rs1_data = rf_q[rs1_addr];
    end

    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else if (wb_we && wb_rd == rs2_addr) begin
      rs2_data = wb_wdata;
    end else begin
      rs2_data = rf_q[rs2_addr];
    end
  end

  tinyrv_if_stage if_stage_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_enable_i  (fetch_enable_i),
    .boot_addr_i     (boot_addr_i),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .ifid_valid_o    (ifid_valid),
    .ifid_pc_o       (ifid_pc),
    .ifid_instr_o    (ifid_instr)
  );

  tinyrv_id_stage id_stage_i (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .ifid_valid_i         (ifid_valid),
    .ifid_pc_i            (ifid_pc),
    .ifid_instr_i         (ifid_instr),
    .rs1_addr_o           (rs1_addr),
    .rs2_addr_o           (rs2_addr),
    .rs1_data_i           (rs1_data),
    .rs2_data_i           (rs2_data),
    .flush_i              (branch_taken),
    .idex_valid_o         (idex_valid),
    .idex_pc_o            (idex_pc),
    .idex_alu_op_o        (idex_alu_op),
    .idex_operand_a_o     (idex_operand_a),
    .idex_operand_b_o     (idex_operand_b),
    .idex_rd_o            (idex_rd),
    .idex_we_o            (idex_we),
    .idex_is_branch_o     (idex_is_branch),
    .idex_branch_ne_o     (idex_branch_ne),
    .idex_is_jal_o        (idex_is_jal),
    .idex_branch_target_o (idex_branch_target),
    .idex_illegal_o       (idex_illegal)
  );

  tinyrv_ex_stage ex_stage_i (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .idex_valid_i         (idex_valid),
    .idex_pc_i            (idex_pc),
    .idex_alu_op_i        (idex_alu_op),
    .idex_operand_a_i     (idex_operand_a),
    .idex_operand_b_i     (idex_operand_b),
    .idex_rd_i            (idex_rd),
    .idex_we_i            (idex_we),
    .idex_is_branch_i     (idex_is_branch),
    .idex_branch_ne_i     (idex_branch_ne),
    .idex_is_jal_i        (idex_is_jal),
    .idex_branch_target_i (idex_branch_target),
    .idex_illegal_i       (idex_illegal),
    .wb_we_o              (wb_we),
    .wb_rd_o              (wb_rd),
    .wb_wdata_o           (wb_wdata),
    .branch_taken_o       (branch_taken),
    .branch_target_o      (branch_target),
    .retire_valid_o       (retire_valid_o),
    .retire_pc_o          (retire_pc_o),
    .retire_we_o          (retire_we_o),
    .retire_rd_o          (retire_rd_o),
    .retire_wdata_o       (retire_wdata_o),
    .retire_illegal_o     (retire_illegal_o)
  );

endmodule

`default_nettype wire

//--- hdl/tinyrv_wrapper.sv
// Subsystem top level holding the tinyrv core and exposing its fetch and retirement ports
`timescale 1ns/1ps
`default_nettype none

module tinyrv_wrapper (
  // Clock and reset
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  // Static configuration and run control
  input  logic                              fetch_enable_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       boot_addr_i,

  // Instruction memory port
  output logic                              instr_req_o,
  output logic [tinyrv_pkg::XLEN-1:0]       instr_addr_o,
  input  logic                              instr_gnt_i,
  input  logic                              instr_rvalid_i,
  input  logic [tinyrv_pkg::XLEN-1:0]       instr_rdata_i,

  // Retirement trace
  output logic                              retire_valid_o,
  output logic [tinyrv_pkg::XLEN-1:0]       retire_pc_o,
  output logic                              retire_we_o,
  output logic [tinyrv_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [tinyrv_pkg::XLEN-1:0]       retire_wdata_o,
  output logic                              retire_illegal_o
);

  // Port names match one to one
  tinyrv_core core_i (.*);

endmodule

`default_nettype wire

//--- test/tinyrv_clk_gen.sv
// Free-running testbench clock with an 8 ns period for the tinyrv testbench
`timescale 1ns/1ps
`default_nettype none

module tinyrv_clk_gen (
  output logic clk_o
);

  localparam realtime HALF_PERIOD = 4.0ns;

  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(HALF_PERIOD) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- test/tinyrv_assertions.sv
// Concurrent checks on the fetch handshake, bound into every tinyrv_if_stage instance
`timescale 1ns/1ps
`default_nettype none

module tinyrv_assertions (
  input wire logic                        clk_i,
  input wire logic                        rst_n_i,
  input wire logic                        fetch_enable_i,
  input wire logic                        instr_req_o,
  input wire logic [tinyrv_pkg::XLEN-1:0] instr_addr_o,
  input wire logic                        instr_gnt_i,
  input wire logic                        instr_rvalid_i,
  input wire logic                        outstanding_q
);

  // Number of failed checks, read by the testbench
  int unsigned fail_cnt = 0;

  // A pending request keeps its address until granted
  req_held_until_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o))
  ) else begin
    $error("Request dropped or address changed before gnt");
    fail_cnt++;
  end

  // Responses only for a fetch in flight
  rvalid_needs_outstanding: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    instr_rvalid_i |-> outstanding_q
  ) else begin
    $error("rvalid without an outstanding fetch");
    fail_cnt++;
  end

  new_req_needs_enable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(instr_req_o) |-> fetch_enable_i
  ) else begin
    $error("Request raised while fetch is disabled");
    fail_cnt++;
  end

endmodule

bind tinyrv_if_stage tinyrv_assertions assertions_i (.*);

`default_nettype wire

//--- test/tinyrv_tb.sv
// Top-level testbench: loads program and expected trace, serves fetches, checks retirement
`timescale 1ns/1ps
`default_nettype none

module tinyrv_tb;

  import tinyrv_pkg::*;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  fetch_enable_i;
  logic [XLEN-1:0]       boot_addr_i;
  logic                  instr_req_o;
  logic [XLEN-1:0]       instr_addr_o;
  logic                  instr_gnt_i;
  logic                  instr_rvalid_i;
  logic [XLEN-1:0]       instr_rdata_i;
  logic                  retire_valid_o;
  logic [XLEN-1:0]       retire_pc_o;
  logic                  retire_we_o;
  logic [REG_ADDR_W-1:0] retire_rd_o;
  logic [XLEN-1:0]       retire_wdata_o;
  logic                  retire_illegal_o;

  // Program image and expected trace
  logic [XLEN-1:0] mem [logic [XLEN-1:0]];
  logic [XLEN-1:0] exp_pc [$];
  logic [XLEN-1:0] exp_we [$];
  logic [XLEN-1:0] exp_rd [$];
  logic [XLEN-1:0] exp_wdata [$];
  logic [XLEN-1:0] exp_illegal [$];

  integer          seed = 40;
  int              ret_idx = 0;
  int              gnt_cnt = 0;
  int              resp_cnt = 0;
  bit              resp_pending = 1'b0;
  logic [XLEN-1:0] resp_addr;

  tinyrv_clk_gen clk_gen_i (.clk_o(clk_i));

  tinyrv_wrapper UUT (.*);

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] expected);
    if (got !== expected) begin
      stop_on_failure($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, expected));
    end
  endtask

  task automatic load_input_file();
    int              fd;
    string           line;
    logic [XLEN-1:0] f [5];
    fd = $fopen("test/tinyrv_input.txt", "r");
    if (fd == 0) begin
      stop_on_failure("Could not open the input data file test/tinyrv_input.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "M %h %h", f[0], f[1]) == 2) begin
        mem[f[0]] = f[1];
      end else if ($sscanf(line, "E %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]) == 5) begin
        exp_pc.push_back(f[0]);
        exp_we.push_back(f[1]);
        exp_rd.push_back(f[2]);
        exp_wdata.push_back(f[3]);
        exp_illegal.push_back(f[4]);
      end else if ($sscanf(line, "B %h", f[0]) == 1) begin
        boot_addr_i = f[0];
      end
    end
    $fclose(fd);
  endtask

  // Instruction memory with random gnt and rvalid delays
  // Addresses outside the image are never granted, which ends the program
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      resp_pending = 1'b0;
      gnt_cnt      = $unsigned($random(seed)) % 4;
    end else begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      if (instr_req_o && instr_gnt_i) begin
        resp_addr    = instr_addr_o;
        resp_cnt     = $unsigned($random(seed)) % 3;
        resp_pending = 1'b1;
        gnt_cnt      = $unsigned($random(seed)) % 4;
      end else if (instr_req_o && mem.exists(instr_addr_o)) begin
        if (gnt_cnt == 0) begin
          instr_gnt_i <= 1'b1;
        end else begin
          gnt_cnt--;
        end
      end
      if (resp_pending) begin
        if (resp_cnt == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= mem[resp_addr];
          resp_pending = 1'b0;
        end else begin
          resp_cnt--;
        end
      end
    end
  end

  // Retirement monitor; rd and wdata only matter when the write is enabled
  always @(posedge clk_i) begin
    if (rst_n_i && retire_valid_o) begin
      if (ret_idx >= exp_pc.size()) begin
        stop_on_failure("An extra instruction retired after the end of the expected trace");
      end else begin
        check_value("retire_pc_o", retire_pc_o, exp_pc[ret_idx]);
        check_value("retire_we_o", retire_we_o, exp_we[ret_idx]);
        check_value("retire_illegal_o", retire_illegal_o, exp_illegal[ret_idx]);
        if (exp_we[ret_idx][0]) begin
          check_value("retire_rd_o", retire_rd_o, exp_rd[ret_idx]);
          check_value("retire_wdata_o", retire_wdata_o, exp_wdata[ret_idx]);
        end
        ret_idx++;
      end
    end
  end

  // Bound fetch checker
  always @(posedge clk_i) begin
    if (UUT.core_i.if_stage_i.assertions_i.fail_cnt != 0) begin
      stop_on_failure("A fetch handshake assertion failed");
    end
  end

  initial begin
    int cycles;
    int limit;
    bit first_req_seen;
    rst_n_i        = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = NOP_INSTR;
    cycles         = 0;
    first_req_seen = 1'b0;
    load_input_file();
    limit = 100 + 10 * exp_pc.size();

    // Reset values show from the second reset edge on
    @(posedge clk_i);
    repeat (3) begin
      @(posedge clk_i);
      check_value("instr_req_o in reset", instr_req_o, 1'b0);
      check_value("retire_valid_o in reset", retire_valid_o, 1'b0);
    end
    rst_n_i <= 1'b1;

    // Out of reset but fetch still disabled
    repeat (5) begin
      @(posedge clk_i);
      check_value("instr_req_o", instr_req_o, 1'b0);
      check_value("retire_valid_o", retire_valid_o, 1'b0);
    end
    fetch_enable_i <= 1'b1;

    while (ret_idx < exp_pc.size()) begin
      @(posedge clk_i);
      cycles++;
      if (!first_req_seen && instr_req_o) begin
        check_value("first instr_addr_o", instr_addr_o, boot_addr_i);
        first_req_seen = 1'b1;
      end
      if (cycles > limit) begin
        stop_on_failure("Timeout: retirement stalled before the expected trace was complete");
      end
    end

    repeat (20) @(posedge clk_i);
    @(negedge clk_i);
    if (UUT.core_i.if_stage_i.assertions_i.fail_cnt == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stop_on_failure("A fetch handshake assertion failed");
    end
  end

endmodule

`default_nettype wire

//--- test/tinyrv_input.txt
# M <addr> <word>: instruction memory image
# E <pc> <we> <rd> <wdata> <illegal>: expected retirement; B <addr>: boot address
M 00000080 123450b7
M 00000084 67808093
M 00000088 ffb00113
M 0000008c 002081b3
M 00000090 40118233
M 00000094 000222b3
M 00000098 0ff0c313
M 0000009c 0f037393
M 000000a0 f003e413
M 000000a4 001474b3
M 000000a8 0054e533
M 000000ac 001545b3
M 000000b0 1005a613
M 000000b4 00560663
M 000000b8 11100693
M 000000bc 22200693
M 000000c0 00561463
M 000000c4 00061663
M 000000c8 33300693
M 000000cc 44400693
M 000000d0 00c0076f
M 000000d4 55500693
M 000000d8 66600693
M 000000dc 00000000
M 000000e0 00508013
M 000000e4 00e007b3
E 00000080 1 01 12345000 0
E 00000084 1 01 12345678 0
E 00000088 1 02 fffffffb 0
E 0000008c 1 03 12345673 0
E 00000090 1 04 fffffffb 0
E 00000094 1 05 00000001 0
E 00000098 1 06 12345687 0
E 0000009c 1 07 00000080 0
E 000000a0 1 08 ffffff80 0
E 000000a4 1 09 12345600 0
E 000000a8 1 0a 12345601 0
E 000000ac 1 0b 00000079 0
E 000000b0 1 0c 00000001 0
E 000000b4 0 00 00000000 0
E 000000c0 0 00 00000000 0
E 000000c4 0 00 00000000 0
E 000000d0 1 0e 000000d4 0
E 000000dc 0 00 00000000 1
E 000000e0 0 00 00000000 0
E 000000e4 1 0f 000000d4 0
B 00000080

//--- tinyrv.f
hdl/tinyrv_pkg.sv
hdl/tinyrv_if_stage.sv
hdl/tinyrv_id_stage.sv
hdl/tinyrv_ex_stage.sv
hdl/tinyrv_core.sv
hdl/tinyrv_wrapper.sv
test/tinyrv_clk_gen.sv
test/tinyrv_assertions.sv
test/tinyrv_tb.sv

//--- Bender.yml
package:
  name: tinyrv

sources:
  - files:
      - hdl/tinyrv_pkg.sv
      - hdl/tinyrv_if_stage.sv
      - hdl/tinyrv_id_stage.sv
      - hdl/tinyrv_ex_stage.sv
      - hdl/tinyrv_core.sv
      - hdl/tinyrv_wrapper.sv
  - target: test
    files:
      - test/tinyrv_clk_gen.sv
      - test/tinyrv_assertions.sv
      - test/tinyrv_tb.sv
